/* common/uart_pkg.sv */
/*
 * shared definitions for the line echo design
 * line size, byte count width, ASCII control codes
 * rx beat and line structs
 */
package uart_pkg;

    // line geometry
    localparam int LINE_BYTES = 16;         // max payload bytes per line
    localparam int LEN_W      = 5;          // holds 0..LINE_BYTES

    // control characters seen on the serial line
    localparam logic [7:0] ASCII_CR = 8'h0D;    // carriage return
    localparam logic [7:0] ASCII_LF = 8'h0A;    // line feed

    // one received byte, valid for a single cycle
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } rx_beat_t;

    // one complete line
    // byte 0 sits in the low bits of bytes
    typedef struct packed {
        logic [LEN_W-1:0]                len;     // number of payload bytes
        logic [LINE_BYTES-1:0][7:0]      bytes;   // payload, unused tail is don't care
    } line_t;

endpackage

/* hw/uart/uart_rx.sv */
`timescale 1ns/1ps
/*
 * 8N1 serial receiver
 * two-flop input sync, start edge detect, mid-bit sampling,
 * stop bit framing check, one-cycle valid per good byte
 */
module uart_rx #(
    parameter int CLK_FREQ  = 50_000_000,
    parameter int BAUD_RATE = 115_200
) (
    input  logic               sys_clk,
    input  logic               sys_rst_n,
    input  logic               uart_rx_port,
    output uart_pkg::rx_beat_t rx_beat
);

    localparam int CLKS_PER_BIT = CLK_FREQ / BAUD_RATE;
    localparam int CNT_W        = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] BIT_END  = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_END = CNT_W'(CLKS_PER_BIT / 2 - 1);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t        state;
    logic             rx_meta, rx_sync, rx_prev;   // sync chain + edge history
    logic [CNT_W-1:0] clk_cnt;                     // clocks inside current bit
    logic [2:0]       bit_idx;                     // data bit number
    logic [7:0]       shift_reg;                   // assembled byte, no reset
    logic             beat_valid;

    assign rx_beat = '{valid: beat_valid, data: shift_reg};

    // line idles high, so the chain resets to 1
    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= uart_rx_port;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            state      <= RX_IDLE;
            clk_cnt    <= '0;
            bit_idx    <= '0;
            beat_valid <= 1'b0;
        end else begin
            beat_valid <= 1'b0;                    // pulse by default off
            case (state)
                RX_IDLE: if (rx_prev && !rx_sync) begin   // falling edge = start
                    state   <= RX_START;
                    clk_cnt <= '0;
                end
                RX_START: if (clk_cnt == HALF_END) begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    state   <= rx_sync ? RX_IDLE : RX_DATA;   // high here is a glitch
                end else begin
                    clk_cnt <= clk_cnt + 1'b1;
                end
                RX_DATA: if (clk_cnt == BIT_END) begin
                    clk_cnt <= '0;
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == 3'd7)
                        state <= RX_STOP;
                end else begin
                    clk_cnt <= clk_cnt + 1'b1;
                end
                RX_STOP: if (clk_cnt == BIT_END) begin
                    clk_cnt    <= '0;
                    beat_valid <= rx_sync;         // low stop bit drops the byte
                    state      <= RX_IDLE;
                end else begin
                    clk_cnt <= clk_cnt + 1'b1;
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // lsb arrives first, shift in from the top
    always_ff @(posedge sys_clk) begin
        if (state == RX_DATA && clk_cnt == BIT_END)
            shift_reg <= {rx_sync, shift_reg[7:1]};
    end

endmodule

/* hw/uart/uart_tx.sv */
`timescale 1ns/1ps
/*
 * 8N1 serial transmitter
 * byte taken on a four-phase req/ack handshake,
 * ack raised once the stop bit has fully ended
 */
module uart_tx #(
    parameter int CLK_FREQ  = 50_000_000,
    parameter int BAUD_RATE = 115_200
) (
    input  logic       sys_clk,
    input  logic       sys_rst_n,
    input  logic [7:0] tx_byte,
    input  logic       tx_req,
    output logic       tx_ack,
    output logic       uart_tx_port
);

    localparam int CLKS_PER_BIT = CLK_FREQ / BAUD_RATE;
    localparam int CNT_W        = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] BIT_END = CNT_W'(CLKS_PER_BIT - 1);

    typedef enum logic [1:0] {TX_IDLE, TX_SEND, TX_ACK} tx_state_t;

    tx_state_t        state;
    logic [CNT_W-1:0] clk_cnt;
    logic [3:0]       bit_idx;     // bits finished, start bit is 0
    logic [8:0]       frame;       // data bits then stop bit, no reset

    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            state        <= TX_IDLE;
            clk_cnt      <= '0;
            bit_idx      <= '0;
            tx_ack       <= 1'b0;
            uart_tx_port <= 1'b1;                  // idle high
        end else begin
            case (state)
                TX_IDLE: if (tx_req) begin
                    frame        <= {1'b1, tx_byte};
                    uart_tx_port <= 1'b0;          // start bit
                    clk_cnt      <= '0;
                    bit_idx      <= '0;
                    state        <= TX_SEND;
                end
                TX_SEND: if (clk_cnt == BIT_END) begin
                    clk_cnt <= '0;
                    if (bit_idx == 4'd9) begin     // stop bit just ended
                        tx_ack <= 1'b1;
                        state  <= TX_ACK;
                    end else begin
                        uart_tx_port <= frame[0];
                        frame        <= frame >> 1;
                        bit_idx      <= bit_idx + 1'b1;
                    end
                end else begin
                    clk_cnt <= clk_cnt + 1'b1;
                end
                TX_ACK: if (!tx_req) begin         // phase 4
                    tx_ack <= 1'b0;
                    state  <= TX_IDLE;
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

endmodule

/* hw/line/line_assembler.sv */
`timescale 1ns/1ps
/*
 * line builder on the receive side
 * stores bytes, drops CR, closes a line on LF or when full,
 * then offers it on a four-phase req/ack handshake
 */
module line_assembler (
    input  logic               sys_clk,
    input  logic               sys_rst_n,
    input  uart_pkg::rx_beat_t rx_beat,
    output uart_pkg::line_t    line_in,
    output logic               line_in_req,
    input  logic               line_in_ack
);

    localparam int IDX_W = $clog2(uart_pkg::LINE_BYTES);

    logic [uart_pkg::LINE_BYTES-1:0][7:0] buf_bytes;   // line storage, no reset
    logic [uart_pkg::LEN_W-1:0]           wr_cnt;      // next free slot
    logic [uart_pkg::LEN_W-1:0]           line_len;    // length of closed line
    logic                                 busy;        // handshake in progress
    logic                                 is_cr, is_lf;

    assign line_in = '{len: line_len, bytes: buf_bytes};
    assign busy    = line_in_req | line_in_ack;        // bytes dropped meanwhile
    assign is_cr   = (rx_beat.data == uart_pkg::ASCII_CR);
    assign is_lf   = (rx_beat.data == uart_pkg::ASCII_LF);

    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            wr_cnt      <= '0;
            line_len    <= '0;
            line_in_req <= 1'b0;
        end else if (line_in_req) begin
            if (line_in_ack)
                line_in_req <= 1'b0;                   // phase 3
        end else if (!line_in_ack && rx_beat.valid && !is_cr) begin
            if (is_lf) begin                           // LF closes, not stored
                line_len    <= wr_cnt;
                line_in_req <= 1'b1;
                wr_cnt      <= '0;
            end else if (wr_cnt == uart_pkg::LEN_W'(uart_pkg::LINE_BYTES - 1)) begin
                line_len    <= uart_pkg::LEN_W'(uart_pkg::LINE_BYTES);   // full line
                line_in_req <= 1'b1;
                wr_cnt      <= '0;
            end else begin
                wr_cnt <= wr_cnt + 1'b1;
            end
        end
    end

    // payload write, only for ordinary bytes outside a handshake
    always_ff @(posedge sys_clk) begin
        if (!busy && rx_beat.valid && !is_cr && !is_lf)
            buf_bytes[wr_cnt[IDX_W-1:0]] <= rx_beat.data;
    end

endmodule

/* hw/line/line_sender.sv */
`timescale 1ns/1ps
/*
 * line walker on the transmit side
 * feeds len payload bytes then CR and LF to the transmitter,
 * one full req/ack cycle per byte, acks the line when done
 */
module line_sender (
    input  logic            sys_clk,
    input  logic            sys_rst_n,
    input  uart_pkg::line_t line_out,
    input  logic            line_out_req,
    output logic            line_out_ack,
    output logic [7:0]      tx_byte,
    output logic            tx_req,
    input  logic            tx_ack
);

    localparam int IDX_W = $clog2(uart_pkg::LINE_BYTES);

    typedef enum logic [1:0] {SND_IDLE, SND_REQ, SND_REL, SND_DONE} snd_state_t;

    snd_state_t                 state;
    logic [uart_pkg::LEN_W-1:0] idx;        // bytes handed over so far
    logic [uart_pkg::LEN_W-1:0] end_idx;    // payload plus CR and LF
    logic [7:0]                 next_byte;

    // line_out is held by the controller until our ack falls
    assign end_idx = line_out.len + uart_pkg::LEN_W'(2);

    // payload first, then the two line end codes
    always_comb begin
        if (idx < line_out.len)
            next_byte = line_out.bytes[idx[IDX_W-1:0]];
        else if (idx == line_out.len)
            next_byte = uart_pkg::ASCII_CR;
        else
            next_byte = uart_pkg::ASCII_LF;
    end

    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            state        <= SND_IDLE;
            idx          <= '0;
            tx_byte      <= '0;
            tx_req       <= 1'b0;
            line_out_ack <= 1'b0;
        end else begin
            case (state)
                SND_IDLE: if (line_out_req) begin
                    tx_byte <= next_byte;          // idx is 0 here
                    tx_req  <= 1'b1;
                    state   <= SND_REQ;
                end
                SND_REQ: if (tx_ack) begin         // stop bit of this byte has ended
                    tx_req <= 1'b0;                // phase 3
                    idx    <= idx + 1'b1;
                    state  <= SND_REL;
                end
                SND_REL: if (!tx_ack) begin        // phase 4 seen, next req allowed
                    if (idx == end_idx) begin
                        idx          <= '0;
                        line_out_ack <= 1'b1;      // trailing LF went out
                        state        <= SND_DONE;
                    end else begin
                        tx_byte <= next_byte;
                        tx_req  <= 1'b1;
                        state   <= SND_REQ;
                    end
                end
                SND_DONE: if (!line_out_req) begin
                    line_out_ack <= 1'b0;          // controller frees its slot on this fall
                    state        <= SND_IDLE;
                end
                default: state <= SND_IDLE;
            endcase
        end
    end

endmodule

/* hw/uart_echo_ctrl.sv */
`timescale 1ns/1ps
/*
 * echo controller
 * one-line slot between assembler and sender,
 * both handshake sides, first byte published on rx_data
 */
module uart_echo_ctrl (
    input  logic            sys_clk,
    input  logic            sys_rst_n,
    input  uart_pkg::line_t line_in,
    input  logic            line_in_req,
    output logic            line_in_ack,
    output uart_pkg::line_t line_out,
    output logic            line_out_req,
    input  logic            line_out_ack,
    output logic [7:0]      rx_data
);

    uart_pkg::line_t slot;          // line in flight, no reset
    logic            slot_full;
    logic            in_ack_d;      // for ack fall on the input side
    logic            out_ack_d;     // for ack fall on the output side

    assign line_out = slot;         // held until line_out_ack falls

    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            slot_full    <= 1'b0;
            line_in_ack  <= 1'b0;
            line_out_req <= 1'b0;
            in_ack_d     <= 1'b0;
            out_ack_d    <= 1'b0;
            rx_data      <= 8'd0;
        end else begin
            in_ack_d  <= line_in_ack;
            out_ack_d <= line_out_ack;
            // input side
            if (line_in_req && !line_in_ack && !slot_full) begin
                line_in_ack <= 1'b1;
                slot_full   <= 1'b1;
                if (line_in.len != '0)
                    rx_data <= line_in.bytes[0];   // empty line keeps old value
            end else if (line_in_ack && !line_in_req) begin
                line_in_ack <= 1'b0;               // phase 4
            end
            // output side, launch one cycle after input ack fell
            if (in_ack_d && !line_in_ack)
                line_out_req <= 1'b1;
            else if (line_out_req && line_out_ack)
                line_out_req <= 1'b0;
            if (out_ack_d && !line_out_ack)
                slot_full <= 1'b0;                 // sender finished
        end
    end

    always_ff @(posedge sys_clk) begin
        if (line_in_req && !line_in_ack && !slot_full)
            slot <= line_in;
    end

endmodule

/* hw/uart_echo_top.sv */
`timescale 1ns/1ps
/*
 * UART line echo top level
 * receiver, line assembler, echo controller, line sender, transmitter
 */
module uart_echo_top #(
    parameter int CLK_FREQ  = 50_000_000,
    parameter int BAUD_RATE = 115_200
) (
    input  logic       sys_clk,
    input  logic       sys_rst_n,
    input  logic       uart_rx_port,
    output logic       uart_tx_port,
    output logic [7:0] rx_data
);

    uart_pkg::rx_beat_t rx_beat;
    uart_pkg::line_t    line_in, line_out;
    logic               line_in_req, line_in_ack;
    logic               line_out_req, line_out_ack;
    logic [7:0]         tx_byte;
    logic               tx_req, tx_ack;

    // input side
    uart_rx #(.CLK_FREQ(CLK_FREQ), .BAUD_RATE(BAUD_RATE)) ins_uart_rx (
        .sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
        .uart_rx_port(uart_rx_port), .rx_beat(rx_beat)
    );
    line_assembler ins_line_assembler (
        .sys_clk(sys_clk), .sys_rst_n(sys_rst_n), .rx_beat(rx_beat),
        .line_in(line_in), .line_in_req(line_in_req), .line_in_ack(line_in_ack)
    );

    // one line slot
    uart_echo_ctrl ins_uart_echo_ctrl (
        .sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
        .line_in(line_in), .line_in_req(line_in_req), .line_in_ack(line_in_ack),
        .line_out(line_out), .line_out_req(line_out_req), .line_out_ack(line_out_ack),
        .rx_data(rx_data)
    );

    // output side
    line_sender ins_line_sender (
        .sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
        .line_out(line_out), .line_out_req(line_out_req), .line_out_ack(line_out_ack),
        .tx_byte(tx_byte), .tx_req(tx_req), .tx_ack(tx_ack)
    );
    uart_tx #(.CLK_FREQ(CLK_FREQ), .BAUD_RATE(BAUD_RATE)) ins_uart_tx (
        .sys_clk(sys_clk), .sys_rst_n(sys_rst_n), .tx_byte(tx_byte),
        .tx_req(tx_req), .tx_ack(tx_ack), .uart_tx_port(uart_tx_port)
    );

endmodule

/* dv/tb_uart_echo.sv */
`timescale 1ns/1ps
/*
 * testbench for the UART line echo top level
 * clock, reset, serial driver and monitor, LFSR stimulus,
 * line reference model, assertions on the echo and rx_data
 */
module tb_uart_echo;

    localparam int CLK_FREQ   = 25_000_000;
    localparam int BAUD_RATE  = 3_125_000;
    localparam int BIT_CLKS   = CLK_FREQ / BAUD_RATE;     // 8 clocks per bit
    localparam int CLK_PERIOD = 40;
    localparam int DRV_DLY    = 2;                        // drive after rising edge
    localparam int MAX_LINE   = 16;
    localparam logic [7:0] CR = 8'h0D;
    localparam logic [7:0] LF = 8'h0A;

    logic       sys_clk;
    logic       sys_rst_n;
    logic       uart_rx_port;
    logic       uart_tx_port;
    logic [7:0] rx_data;

    logic [15:0] lfsr;                  // galois state
    logic        quiet;                 // no echo may appear
    logic [7:0]  line_q[$];             // bytes of the next line to drive
    int          bad_idx;               // byte sent with a low stop bit, -1 for none
    logic [7:0]  model_buf[$];          // model of the line being assembled
    logic [7:0]  exp_q[$];              // expected echo bytes
    logic [7:0]  exp_rx_data;
    logic [7:0]  mon_q[$];              // bytes seen on uart_tx_port
    int          mismatch_cnt, timeout_cnt, other_cnt;

    int          mon_cnt;               // edges since start bit seen
    logic        mon_busy;
    logic [7:0]  mon_shift;

    uart_echo_top #(.CLK_FREQ(CLK_FREQ), .BAUD_RATE(BAUD_RATE)) i_dut (
        .sys_clk(sys_clk), .sys_rst_n(sys_rst_n), .uart_rx_port(uart_rx_port),
        .uart_tx_port(uart_tx_port), .rx_data(rx_data)
    );

    initial sys_clk = 1'b0;
    always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

    // idle line after reset
    a_tx_idle: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        quiet |-> uart_tx_port)
        else begin
            mismatch_cnt++;
            $display("mismatch uart_tx_port: got 0x%0h, expected 0x1", $sampled(uart_tx_port));
        end
    a_rx_data_rst: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        quiet |-> (rx_data == 8'h00))
        else begin
            mismatch_cnt++;
            $display("mismatch rx_data: got 0x%02h, expected 0x00", $sampled(rx_data));
        end
    a_tx_known: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        !$isunknown(uart_tx_port))
        else begin
            other_cnt++;
            $display("uart_tx_port is unknown after reset");
        end

    // serial monitor, samples every bit at its middle
    always @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            mon_busy = 1'b0;
            mon_cnt  = 0;
        end else if (!mon_busy) begin
            if (!uart_tx_port) begin            // start bit
                mon_busy = 1'b1;
                mon_cnt  = 0;
            end
        end else begin
            mon_cnt = mon_cnt + 1;
            if (mon_cnt % BIT_CLKS == BIT_CLKS / 2) begin
                if (mon_cnt / BIT_CLKS <= 8) begin
                    mon_shift = {uart_tx_port, mon_shift[7:1]};   // lsb first
                end else begin
                    a_stop: assert (uart_tx_port)
                        else begin
                            other_cnt++;
                            $display("stop bit on uart_tx_port was low");
                        end
                    mon_q.push_back(mon_shift);
                    mon_busy = 1'b0;
                end
            end
        end
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic rand_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            v    = v | (int'(lfsr[0]) << i);
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic add_random(input int n);
        int v;
        logic [7:0] b;
        for (int i = 0; i < n; i++) begin
            rand_bits(8, v);
            b = v[7:0];
            if (b == CR || b == LF)
                b = b ^ 8'h20;                  // keep control codes out
            line_q.push_back(b);
        end
    endtask

    // line closes: payload, then CR LF
    task automatic model_close();
        if (model_buf.size() > 0)
            exp_rx_data = model_buf[0];         // empty line keeps it
        foreach (model_buf[i])
            exp_q.push_back(model_buf[i]);
        exp_q.push_back(CR);
        exp_q.push_back(LF);
        model_buf.delete();
    endtask

    task automatic model_byte(input logic [7:0] b);
        if (b == LF) begin
            model_close();
        end else if (b != CR) begin             // CR never stored
            model_buf.push_back(b);
            if (model_buf.size() == MAX_LINE)
                model_close();
        end
    endtask

    // 8N1 frame, optional low stop bit
    task automatic send_byte(input logic [7:0] b, input logic bad_stop);
        logic [9:0] frame;
        frame = {~bad_stop, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            uart_rx_port = frame[i];
            repeat (BIT_CLKS) @(posedge sys_clk);
            #DRV_DLY;
        end
        if (bad_stop) begin
            uart_rx_port = 1'b1;                // idle so the next start has an edge
            repeat (BIT_CLKS) @(posedge sys_clk);
            #DRV_DLY;
        end
    endtask

    task automatic send_line();
        foreach (line_q[i]) begin
            send_byte(line_q[i], i == bad_idx);
            if (i != bad_idx)
                model_byte(line_q[i]);          // dropped byte never reaches the model
        end
        line_q.delete();
        bad_idx = -1;
    endtask

    task automatic check_echo();
        int waited;
        int limit;
        int idx;
        logic [7:0] got;
        logic [7:0] want;
        limit  = exp_q.size() * BIT_CLKS * 14 + 400;
        waited = 0;
        idx    = 0;
        while (mon_q.size() < exp_q.size() && waited < limit) begin
            @(posedge sys_clk);
            waited++;
        end
        if (mon_q.size() < exp_q.size()) begin
            timeout_cnt++;
            $display("timeout: echo returned %0d of %0d bytes", mon_q.size(), exp_q.size());
        end
        while (exp_q.size() > 0 && mon_q.size() > 0) begin
            got  = mon_q.pop_front();
            want = exp_q.pop_front();
            a_echo: assert (got == want)
                else begin
                    mismatch_cnt++;
                    $display("mismatch uart_tx_port byte %0d: got 0x%02h, expected 0x%02h",
                             idx, got, want);
                end
            idx++;
        end
        exp_q.delete();
        repeat (BIT_CLKS * 12) @(posedge sys_clk);   // window for stray bytes
        #DRV_DLY;
        a_no_extra: assert (mon_q.size() == 0)
            else begin
                other_cnt++;
                $display("echo carried %0d bytes more than expected", mon_q.size());
            end
        mon_q.delete();
    endtask

    task automatic check_rx_data();
        a_rx_data: assert (rx_data == exp_rx_data)
            else begin
                mismatch_cnt++;
                $display("mismatch rx_data: got 0x%02h, expected 0x%02h", rx_data, exp_rx_data);
            end
    endtask

    initial begin
        int len;
        sys_rst_n    = 1'b0;
        uart_rx_port = 1'b1;                    // line idles high
        quiet        = 1'b0;
        lfsr         = 16'd81;
        bad_idx      = -1;
        exp_rx_data  = 8'h00;
        mismatch_cnt = 0;
        timeout_cnt  = 0;
        other_cnt    = 0;
        repeat (4) @(posedge sys_clk);
        #DRV_DLY;
        sys_rst_n = 1'b1;

        // no input, tx stays idle
        quiet = 1'b1;
        repeat (BIT_CLKS * 20) @(posedge sys_clk);
        #DRV_DLY;
        quiet = 1'b0;

        // random lines with CR LF
        for (int n = 0; n < 3; n++) begin
            rand_bits(4, len);
            add_random(len % 10 + 1);
            line_q.push_back(CR);
            line_q.push_back(LF);
            send_line();
            check_echo();
            check_rx_data();
        end

        // bare LF, then empty line, then CRs inside a line
        add_random(5);
        line_q.push_back(LF);
        send_line();
        check_echo();
        check_rx_data();
        line_q.push_back(LF);
        send_line();
        check_echo();
        check_rx_data();
        add_random(2);
        line_q.push_back(CR);
        add_random(3);
        line_q.push_back(CR);
        add_random(1);
        line_q.push_back(LF);
        send_line();
        check_echo();
        check_rx_data();

        // overlong line splits at 16 bytes
        add_random(20);
        send_line();
        check_echo();
        check_rx_data();
        line_q.push_back(LF);
        send_line();
        check_echo();
        check_rx_data();

        // second line while the first is echoing
        add_random(6);
        line_q.push_back(LF);
        send_line();
        add_random(4);
        line_q.push_back(CR);
        line_q.push_back(LF);
        send_line();
        check_echo();
        check_rx_data();

        // framing error drops one byte
        add_random(6);
        bad_idx = 2;
        line_q.push_back(LF);
        send_line();
        check_echo();
        check_rx_data();

        $display("errors: %0d mismatches, %0d timeouts, %0d other failures",
                 mismatch_cnt, timeout_cnt, other_cnt);
        if (mismatch_cnt + timeout_cnt + other_cnt == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

/* src.f */
common/uart_pkg.sv
hw/uart/uart_rx.sv
hw/uart/uart_tx.sv
hw/line/line_assembler.sv
hw/line/line_sender.sv
hw/uart_echo_ctrl.sv
hw/uart_echo_top.sv
dv/tb_uart_echo.sv

/* Makefile */
# Verilator flow for the UART line echo testbench

VERILATOR ?= verilator
TOP       ?= tb_uart_echo
RTL_TOP   ?= uart_echo_top
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation passed
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
